// ==== hdl/uart_pkg.sv ====
////////////////////
// Serial line protocol definitions
// Frame widths, vector types and FSM states
////////////////////

package uart_pkg;

    // Data bits per 8N1 frame
    localparam int UART_DATA_SIZE = 8;

    // Clock cycles per bit are held in this many bits
    localparam int UART_BAUD_DIV_SIZE = 16;

    // Wide enough to count the data bits of one frame
    localparam int UART_BIT_CNT_SIZE = 4;

    typedef logic [UART_DATA_SIZE-1:0]     uart_data_t;
    typedef logic [UART_BAUD_DIV_SIZE-1:0] uart_baud_div_t;
    typedef logic [UART_BIT_CNT_SIZE-1:0]  uart_bit_cnt_t;

    // Receiver FSM
    typedef enum logic [1:0] {
        UART_RX_IDLE,
        UART_RX_START,
        UART_RX_DATA,
        UART_RX_STOP
    } uart_rx_state_e;

    // Transmitter FSM
    typedef enum logic [1:0] {
        UART_TX_IDLE,
        UART_TX_START,
        UART_TX_DATA,
        UART_TX_STOP
    } uart_tx_state_e;

endpackage

// ==== hdl/uart_reg_pkg.sv ====
////////////////////
// Register map definitions
// Offsets, status bits and bus request
////////////////////

package uart_reg_pkg;

    import uart_pkg::*;

    localparam int UART_REG_ADDR_SIZE = 2;

    typedef logic [UART_REG_ADDR_SIZE-1:0] reg_addr_t;

    // Register offsets
    localparam reg_addr_t UART_REG_BAUD   = 2'd0;
    localparam reg_addr_t UART_REG_TXDATA = 2'd1;
    localparam reg_addr_t UART_REG_RXDATA = 2'd2;
    localparam reg_addr_t UART_REG_STATUS = 2'd3;

    // Divisor after reset
    localparam uart_baud_div_t UART_BAUD_RESET_VAL = 16'd16;

    // Bit positions inside STATUS
    localparam int STATUS_TX_BUSY_BIT   = 0;
    localparam int STATUS_RX_VALID_BIT  = 1;
    localparam int STATUS_FRAME_ERR_BIT = 2;
    localparam int STATUS_OVERRUN_BIT   = 3;

    // One bus access, valid in the cycle where en is high
    typedef struct packed {
        logic           en;
        logic           we;
        reg_addr_t      addr;
        uart_baud_div_t wdata;
    } uart_bus_req_t;

endpackage

// ==== hdl/uart_rx.sv ====
////////////////////
// UART receiver, 8N1
////////////////////

`timescale 1ns/1ps

module uart_rx import uart_pkg::*; (
    input  logic           clk,
    input  logic           rst_n,

    input  logic           rx_i,
    input  uart_baud_div_t baud_div_i,

    output uart_data_t     rx_data_o,
    output logic           valid_o,
    output logic           frame_err_o
);

    // Two-stage synchronizer plus one more stage for edge detection
    logic [1:0]     sync_ff;
    logic           rx_prev_ff;
    logic           rx_sync;
    logic           start_edge;

    uart_rx_state_e state_ff, state_next;

    // Bit period counter and start bit half-period counter
    uart_baud_div_t sample_cnt_ff, sample_cnt_next;
    uart_baud_div_t mid_cnt_ff, mid_cnt_next;
    uart_bit_cnt_t  bit_cnt_ff, bit_cnt_next;

    uart_data_t     shift_ff, shift_next;
    logic           valid_ff, valid_next;
    logic           frame_err_ff, frame_err_next;

    logic           sample_pulse;
    logic           start_mid;

    assign rx_sync    = sync_ff[1];
    assign start_edge = rx_prev_ff & ~rx_sync;

    assign sample_pulse = (sample_cnt_ff == '0);
    assign start_mid    = (mid_cnt_ff == (baud_div_i >> 1));

    // Line idles high, so the chain resets to 1
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sync_ff    <= 2'b11;
            rx_prev_ff <= 1'b1;
        end else begin
            sync_ff    <= {sync_ff[0], rx_i};
            rx_prev_ff <= rx_sync;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_ff      <= UART_RX_IDLE;
            sample_cnt_ff <= '0;
            mid_cnt_ff    <= '0;
            bit_cnt_ff    <= '0;
            valid_ff      <= 1'b0;
            frame_err_ff  <= 1'b0;
        end else begin
            state_ff      <= state_next;
            sample_cnt_ff <= sample_cnt_next;
            mid_cnt_ff    <= mid_cnt_next;
            bit_cnt_ff    <= bit_cnt_next;
            valid_ff      <= valid_next;
            frame_err_ff  <= frame_err_next;
        end
    end

    always_ff @(posedge clk) begin
        shift_ff <= shift_next;
    end

    always_comb begin
        state_next      = state_ff;
        sample_cnt_next = sample_cnt_ff;
        mid_cnt_next    = mid_cnt_ff;
        bit_cnt_next    = bit_cnt_ff;
        shift_next      = shift_ff;
        // Status outputs are single-cycle pulses
        valid_next      = 1'b0;
        frame_err_next  = 1'b0;

        case (state_ff)
            UART_RX_IDLE: begin
                mid_cnt_next = '0;
                // Only a falling edge starts a frame, a held-low line is ignored
                if (start_edge) begin
                    state_next = UART_RX_START;
                end
            end

            UART_RX_START: begin
                if (start_mid) begin
                    if (!rx_sync) begin
                        state_next      = UART_RX_DATA;
                        sample_cnt_next = baud_div_i - 1'b1;
                        bit_cnt_next    = uart_bit_cnt_t'(UART_DATA_SIZE);
                    end else begin
                        // Glitch shorter than half a bit
                        state_next = UART_RX_IDLE;
                    end
                end else begin
                    mid_cnt_next = mid_cnt_ff + 1'b1;
                end
            end

            UART_RX_DATA: begin
                if (sample_pulse) begin
                    shift_next      = {rx_sync, shift_ff[UART_DATA_SIZE-1:1]};
                    bit_cnt_next    = bit_cnt_ff - 1'b1;
                    sample_cnt_next = baud_div_i - 1'b1;
                    if (bit_cnt_ff == uart_bit_cnt_t'(1)) begin
                        state_next = UART_RX_STOP;
                    end
                end else begin
                    sample_cnt_next = sample_cnt_ff - 1'b1;
                end
            end

            UART_RX_STOP: begin
                if (sample_pulse) begin
                    state_next = UART_RX_IDLE;
                    if (rx_sync) begin
                        valid_next = 1'b1;
                    end else begin
                        frame_err_next = 1'b1;
                    end
                end else begin
                    sample_cnt_next = sample_cnt_ff - 1'b1;
                end
            end

            default: begin
                state_next = UART_RX_IDLE;
            end
        endcase
    end

    assign rx_data_o   = shift_ff;
    assign valid_o     = valid_ff;
    assign frame_err_o = frame_err_ff;

    // A frame ends either good or bad, never both
    a_rx_single_result: assert property (
        @(posedge clk) disable iff (!rst_n)
        !(valid_o && frame_err_o)
    );

    // Half-bit start detection needs a few cycles per bit
    a_rx_min_divisor: assert property (
        @(posedge clk) disable iff (!rst_n)
        (state_ff == UART_RX_IDLE && state_next != UART_RX_IDLE)
            |-> (baud_div_i >= uart_baud_div_t'(4))
    );

endmodule

// ==== hdl/uart_tx.sv ====
////////////////////
// UART transmitter, 8N1
////////////////////

`timescale 1ns/1ps

module uart_tx import uart_pkg::*; (
    input  logic           clk,
    input  logic           rst_n,

    input  logic           start_i,
    input  uart_data_t     data_i,
    input  uart_baud_div_t baud_div_i,

    output logic           tx_o,
    output logic           busy_o
);

    uart_tx_state_e state_ff, state_next;

    uart_baud_div_t bit_time_ff, bit_time_next;
    uart_bit_cnt_t  bit_cnt_ff, bit_cnt_next;
    uart_data_t     shift_ff, shift_next;
    logic           tx_ff, tx_next;

    logic           bit_done;

    assign bit_done = (bit_time_ff == '0);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_ff    <= UART_TX_IDLE;
            bit_time_ff <= '0;
            bit_cnt_ff  <= '0;
            tx_ff       <= 1'b1;
        end else begin
            state_ff    <= state_next;
            bit_time_ff <= bit_time_next;
            bit_cnt_ff  <= bit_cnt_next;
            tx_ff       <= tx_next;
        end
    end

    always_ff @(posedge clk) begin
        shift_ff <= shift_next;
    end

    always_comb begin
        state_next    = state_ff;
        bit_time_next = bit_time_ff;
        bit_cnt_next  = bit_cnt_ff;
        shift_next    = shift_ff;
        tx_next       = tx_ff;

        case (state_ff)
            UART_TX_IDLE: begin
                tx_next = 1'b1;
                if (start_i) begin
                    state_next    = UART_TX_START;
                    bit_time_next = baud_div_i - 1'b1;
                    bit_cnt_next  = '0;
                    shift_next    = data_i;
                    tx_next       = 1'b0;
                end
            end

            UART_TX_START: begin
                if (bit_done) begin
                    state_next    = UART_TX_DATA;
                    bit_time_next = baud_div_i - 1'b1;
                    tx_next       = shift_ff[0];
                end else begin
                    bit_time_next = bit_time_ff - 1'b1;
                end
            end

            UART_TX_DATA: begin
                if (bit_done) begin
                    bit_time_next = baud_div_i - 1'b1;
                    if (bit_cnt_ff == uart_bit_cnt_t'(UART_DATA_SIZE - 1)) begin
                        state_next = UART_TX_STOP;
                        tx_next    = 1'b1;
                    end else begin
                        // LSB first so the next bit moves into position 0
                        shift_next   = shift_ff >> 1;
                        tx_next      = shift_ff[1];
                        bit_cnt_next = bit_cnt_ff + 1'b1;
                    end
                end else begin
                    bit_time_next = bit_time_ff - 1'b1;
                end
            end

            UART_TX_STOP: begin
                if (bit_done) begin
                    state_next = UART_TX_IDLE;
                end else begin
                    bit_time_next = bit_time_ff - 1'b1;
                end
            end

            default: begin
                state_next = UART_TX_IDLE;
            end
        endcase
    end

    assign tx_o   = tx_ff;
    assign busy_o = (state_ff != UART_TX_IDLE);

    a_tx_idle_high: assert property (
        @(posedge clk) disable iff (!rst_n)
        (state_ff == UART_TX_IDLE) |-> tx_o
    );

endmodule

// ==== hdl/uart_regs.sv ====
////////////////////
// UART register block
// Divisor, tx trigger, rx byte, status
////////////////////

`timescale 1ns/1ps

module uart_regs import uart_pkg::*, uart_reg_pkg::*; (
    input  logic           clk,
    input  logic           rst_n,

    input  uart_bus_req_t  bus_req_i,
    output logic [15:0]    bus_rdata_o,

    output uart_baud_div_t baud_div_o,
    output logic           tx_start_o,
    output uart_data_t     tx_data_o,
    input  logic           tx_busy_i,

    input  uart_data_t     rx_data_i,
    input  logic           rx_valid_i,
    input  logic           frame_err_i
);

    logic           wr_en;
    logic           rd_en;
    logic           wr_baud;
    logic           wr_txdata;
    logic           rd_rxdata;
    logic           rd_status;

    uart_baud_div_t baud_ff;
    logic           tx_start_ff;
    uart_data_t     tx_data_ff;
    uart_data_t     rx_byte_ff;
    logic           rx_valid_ff;
    logic           frame_err_ff;
    logic           overrun_ff;
    logic [15:0]    rdata_ff;
    logic [15:0]    rd_mux;

    // Access decode
    assign wr_en     = bus_req_i.en & bus_req_i.we;
    assign rd_en     = bus_req_i.en & ~bus_req_i.we;
    assign wr_baud   = wr_en && (bus_req_i.addr == UART_REG_BAUD);
    assign wr_txdata = wr_en && (bus_req_i.addr == UART_REG_TXDATA);
    assign rd_rxdata = rd_en && (bus_req_i.addr == UART_REG_RXDATA);
    assign rd_status = rd_en && (bus_req_i.addr == UART_REG_STATUS);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            baud_ff     <= UART_BAUD_RESET_VAL;
            tx_start_ff <= 1'b0;
            rdata_ff    <= '0;
        end else begin
            if (wr_baud) begin
                baud_ff <= bus_req_i.wdata;
            end
            tx_start_ff <= wr_txdata;
            if (rd_en) begin
                rdata_ff <= rd_mux;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_txdata) begin
            tx_data_ff <= bus_req_i.wdata[UART_DATA_SIZE-1:0];
        end
    end

    // Receive side flags, a set in the same cycle as a clear wins
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rx_byte_ff   <= '0;
            rx_valid_ff  <= 1'b0;
            frame_err_ff <= 1'b0;
            overrun_ff   <= 1'b0;
        end else begin
            if (rx_valid_i) begin
                rx_byte_ff <= rx_data_i;
            end

            if (rx_valid_i) begin
                rx_valid_ff <= 1'b1;
            end else if (rd_rxdata) begin
                rx_valid_ff <= 1'b0;
            end

            // New byte on top of an unread one
            if (rx_valid_i && rx_valid_ff) begin
                overrun_ff <= 1'b1;
            end else if (rd_status) begin
                overrun_ff <= 1'b0;
            end

            if (frame_err_i) begin
                frame_err_ff <= 1'b1;
            end else if (rd_status) begin
                frame_err_ff <= 1'b0;
            end
        end
    end

    // Read data, zero-extended to the bus width
    always_comb begin
        rd_mux = '0;
        case (bus_req_i.addr)
            UART_REG_BAUD: begin
                rd_mux = baud_ff;
            end
            UART_REG_RXDATA: begin
                rd_mux[UART_DATA_SIZE-1:0] = rx_byte_ff;
            end
            UART_REG_STATUS: begin
                rd_mux[STATUS_TX_BUSY_BIT]   = tx_busy_i;
                rd_mux[STATUS_RX_VALID_BIT]  = rx_valid_ff;
                rd_mux[STATUS_FRAME_ERR_BIT] = frame_err_ff;
                rd_mux[STATUS_OVERRUN_BIT]   = overrun_ff;
            end
            // TXDATA is write-only and reads back as zero
            default: begin
                rd_mux = '0;
            end
        endcase
    end

    assign bus_rdata_o = rdata_ff;
    assign baud_div_o  = baud_ff;
    assign tx_start_o  = tx_start_ff;
    assign tx_data_o   = tx_data_ff;

endmodule

// ==== hdl/uart_top.sv ====
////////////////////
// UART peripheral top level
////////////////////

`timescale 1ns/1ps

module uart_top import uart_pkg::*, uart_reg_pkg::*; (
    input  logic          clk,
    input  logic          rst_n,

    input  uart_bus_req_t bus_req_i,
    output logic [15:0]   bus_rdata_o,

    input  logic          rx_i,
    output logic          tx_o
);

    uart_baud_div_t baud_div;
    logic           tx_start;
    uart_data_t     tx_data;
    logic           tx_busy;
    uart_data_t     rx_data;
    logic           rx_valid;
    logic           frame_err;

    uart_regs i_uart_regs (
        .clk         (clk),
        .rst_n       (rst_n),
        .bus_req_i   (bus_req_i),
        .bus_rdata_o (bus_rdata_o),
        .baud_div_o  (baud_div),
        .tx_start_o  (tx_start),
        .tx_data_o   (tx_data),
        .tx_busy_i   (tx_busy),
        .rx_data_i   (rx_data),
        .rx_valid_i  (rx_valid),
        .frame_err_i (frame_err)
    );

    uart_rx i_uart_rx (
        .clk         (clk),
        .rst_n       (rst_n),
        .rx_i        (rx_i),
        .baud_div_i  (baud_div),
        .rx_data_o   (rx_data),
        .valid_o     (rx_valid),
        .frame_err_o (frame_err)
    );

    uart_tx i_uart_tx (
        .clk        (clk),
        .rst_n      (rst_n),
        .start_i    (tx_start),
        .data_i     (tx_data),
        .baud_div_i (baud_div),
        .tx_o       (tx_o),
        .busy_o     (tx_busy)
    );

endmodule

// ==== verification/tb_uart_top.sv ====
////////////////////
// UART peripheral testbench
// Bus tasks, serial driver, tx monitor, model
////////////////////

`timescale 1ns/1ps

module tb_uart_top import uart_pkg::*, uart_reg_pkg::*; ();

    localparam int CLK_HALF_NS   = 20;
    localparam int SEED          = 23060;
    localparam int POLL_LIMIT    = 64;
    localparam int TX_WAIT_LIMIT = 64;
    localparam int NUM_FRAMES    = 6;

    localparam logic [15:0] TX_BUSY_MASK   = 16'h1 << STATUS_TX_BUSY_BIT;
    localparam logic [15:0] RX_VALID_MASK  = 16'h1 << STATUS_RX_VALID_BIT;
    localparam logic [15:0] FRAME_ERR_MASK = 16'h1 << STATUS_FRAME_ERR_BIT;
    localparam logic [15:0] OVERRUN_MASK   = 16'h1 << STATUS_OVERRUN_BIT;

    logic           clk;
    logic           rst_n;
    uart_bus_req_t  bus_req;
    logic [15:0]    bus_rdata;
    logic           rx_line;
    logic           tx_line;

    // Expected receive side register contents
    uart_data_t     m_rxdata;
    logic           m_rx_valid;
    logic           m_frame_err;
    logic           m_overrun;

    uart_baud_div_t cur_div;
    int             mismatches;
    int             timeouts;
    int             other_errors;

    uart_top i_uart_top (
        .clk         (clk),
        .rst_n       (rst_n),
        .bus_req_i   (bus_req),
        .bus_rdata_o (bus_rdata),
        .rx_i        (rx_line),
        .tx_o        (tx_line)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_HALF_NS) clk = ~clk;
        end
    end

    task automatic report_mismatch(input string name, input logic [15:0] exp,
                                   input logic [15:0] act);
        mismatches++;
        $display("FAILED %s: expected 0x%0h, actual 0x%0h", name, exp, act);
    endtask

    task automatic report_timeout(input string what);
        timeouts++;
        $display("ERROR: timed out %s", what);
    endtask

    task automatic bus_write(input reg_addr_t addr, input logic [15:0] data);
        @(posedge clk);
        bus_req <= '{en: 1'b1, we: 1'b1, addr: addr, wdata: data};
        @(posedge clk);
        bus_req <= '0;
    endtask

    // Read data is registered, so it is taken in the middle of the next cycle
    task automatic bus_read(input reg_addr_t addr, output logic [15:0] data);
        @(posedge clk);
        bus_req <= '{en: 1'b1, we: 1'b0, addr: addr, wdata: 16'h0000};
        @(posedge clk);
        bus_req <= '0;
        @(negedge clk);
        data = bus_rdata;
    endtask

    function automatic logic [15:0] expected_status(input logic busy);
        logic [15:0] s;
        s = '0;
        s[STATUS_TX_BUSY_BIT]   = busy;
        s[STATUS_RX_VALID_BIT]  = m_rx_valid;
        s[STATUS_FRAME_ERR_BIT] = m_frame_err;
        s[STATUS_OVERRUN_BIT]   = m_overrun;
        return s;
    endfunction

    // A STATUS read clears the sticky flags
    task automatic check_status(input string name, input logic [15:0] act, input logic busy);
        logic [15:0] exp;
        exp = expected_status(busy);
        if (act !== exp) begin
            report_mismatch(name, exp, act);
        end
        m_frame_err = 1'b0;
        m_overrun   = 1'b0;
    endtask

    // Poll STATUS until the masked bits match, then check the whole word
    task automatic poll_status(input string name, input logic [15:0] mask,
                               input logic [15:0] want);
        logic [15:0] rd;
        int          n;
        n = 0;
        bus_read(UART_REG_STATUS, rd);
        while (((rd & mask) != want) && n < POLL_LIMIT) begin
            bus_read(UART_REG_STATUS, rd);
            n++;
        end
        if ((rd & mask) != want) begin
            report_timeout({"polling STATUS in ", name});
        end
        check_status(name, rd, 1'b0);
    endtask

    task automatic read_rxdata(input string name);
        logic [15:0] rd;
        bus_read(UART_REG_RXDATA, rd);
        if (rd !== 16'(m_rxdata)) begin
            report_mismatch(name, 16'(m_rxdata), rd);
        end
        m_rx_valid = 1'b0;
    endtask

    // One 8N1 frame on rx_i with each bit held for cur_div cycles
    task automatic send_frame(input uart_data_t data, input logic stop_bit);
        logic [9:0] bits;
        bits = {stop_bit, data, 1'b0};
        for (int i = 0; i < 10; i++) begin
            @(posedge clk);
            rx_line <= bits[i];
            repeat (int'(cur_div) - 1) @(posedge clk);
        end
        @(posedge clk);
        rx_line <= 1'b1;
    endtask

    function automatic void model_frame(input uart_data_t data, input logic stop_bit);
        if (stop_bit) begin
            if (m_rx_valid) begin
                m_overrun = 1'b1;
            end
            m_rx_valid = 1'b1;
            m_rxdata   = data;
        end else begin
            m_frame_err = 1'b1;
        end
    endfunction

    // Finds the falling edge on tx_o and samples each bit at its middle
    task automatic capture_tx(output uart_data_t data, output logic found);
        int n;
        data  = '0;
        found = 1'b0;
        n     = 0;
        @(negedge clk);
        while (tx_line && n < TX_WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (tx_line) begin
            report_timeout("waiting for a start bit on tx_o");
        end else begin
            found = 1'b1;
            repeat (int'(cur_div) / 2) @(negedge clk);
            if (tx_line !== 1'b0) begin
                report_mismatch("tx start bit", 16'd0, 16'(tx_line));
            end
            for (int i = 0; i < UART_DATA_SIZE; i++) begin
                repeat (int'(cur_div)) @(negedge clk);
                data[i] = tx_line;
            end
            repeat (int'(cur_div)) @(negedge clk);
            if (tx_line !== 1'b1) begin
                report_mismatch("tx stop bit", 16'd1, 16'(tx_line));
            end
        end
    endtask

    function automatic uart_baud_div_t random_div();
        return uart_baud_div_t'(4 + ($urandom % 17));
    endfunction

    initial begin
        logic [15:0] rd;
        uart_data_t  sent;
        uart_data_t  sent2;
        uart_data_t  seen;
        logic        found;
        logic        line_ok;

        void'($urandom(SEED));
        mismatches   = 0;
        timeouts     = 0;
        other_errors = 0;
        m_rxdata     = '0;
        m_rx_valid   = 1'b0;
        m_frame_err  = 1'b0;
        m_overrun    = 1'b0;
        cur_div      = 16'd16;
        rst_n   <= 1'b0;
        bus_req <= '0;
        rx_line <= 1'b1;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;

        // Reset values
        bus_read(UART_REG_BAUD, rd);
        if (rd !== 16'd16) begin
            report_mismatch("reset BAUD", 16'd16, rd);
        end
        bus_read(UART_REG_STATUS, rd);
        check_status("reset STATUS", rd, 1'b0);
        if (tx_line !== 1'b1) begin
            report_mismatch("reset tx_o", 16'd1, 16'(tx_line));
        end

        // Transmit with random divisors and check busy while the frame runs
        for (int t = 0; t < NUM_FRAMES; t++) begin
            cur_div = random_div();
            sent    = uart_data_t'($urandom);
            bus_write(UART_REG_BAUD, cur_div);
            bus_write(UART_REG_TXDATA, 16'(sent));
            fork
                capture_tx(seen, found);
                begin
                    bus_read(UART_REG_STATUS, rd);
                    check_status("tx STATUS busy", rd, 1'b1);
                end
            join
            if (found && seen !== sent) begin
                report_mismatch("tx byte", 16'(sent), 16'(seen));
            end
            poll_status("tx STATUS idle", TX_BUSY_MASK, 16'h0000);
        end

        // Receive good frames
        for (int r = 0; r < NUM_FRAMES; r++) begin
            cur_div = random_div();
            sent    = uart_data_t'($urandom);
            bus_write(UART_REG_BAUD, cur_div);
            send_frame(sent, 1'b1);
            model_frame(sent, 1'b1);
            poll_status("rx STATUS valid", RX_VALID_MASK, RX_VALID_MASK);
            read_rxdata("rx RXDATA");
            bus_read(UART_REG_STATUS, rd);
            check_status("rx STATUS after read", rd, 1'b0);
        end

        // Low stop bit
        sent = uart_data_t'($urandom);
        send_frame(sent, 1'b0);
        model_frame(sent, 1'b0);
        poll_status("frame error STATUS", FRAME_ERR_MASK, FRAME_ERR_MASK);
        bus_read(UART_REG_STATUS, rd);
        check_status("frame error cleared", rd, 1'b0);

        // Second byte lands on an unread first one
        sent  = uart_data_t'($urandom);
        sent2 = uart_data_t'($urandom);
        send_frame(sent, 1'b1);
        model_frame(sent, 1'b1);
        poll_status("overrun first byte", RX_VALID_MASK, RX_VALID_MASK);
        send_frame(sent2, 1'b1);
        model_frame(sent2, 1'b1);
        poll_status("overrun STATUS", OVERRUN_MASK, OVERRUN_MASK);
        read_rxdata("overrun RXDATA");

        // A TXDATA write while busy is dropped
        cur_div = random_div();
        sent    = uart_data_t'($urandom);
        sent2   = uart_data_t'($urandom);
        bus_write(UART_REG_BAUD, cur_div);
        fork
            capture_tx(seen, found);
            begin
                bus_write(UART_REG_TXDATA, 16'(sent));
                bus_write(UART_REG_TXDATA, 16'(sent2));
            end
        join
        if (found && seen !== sent) begin
            report_mismatch("busy write first byte", 16'(sent), 16'(seen));
        end
        line_ok = 1'b1;
        for (int k = 0; k < 12 * int'(cur_div); k++) begin
            @(negedge clk);
            if (tx_line !== 1'b1) begin
                line_ok = 1'b0;
            end
        end
        if (!line_ok) begin
            other_errors++;
            $display("ERROR: tx_o left idle after a TXDATA write while busy");
        end

        $display("Summary: %0d value mismatches, %0d timeouts, %0d other errors",
                 mismatches, timeouts, other_errors);
        if (mismatches == 0 && timeouts == 0 && other_errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== project.f ====
hdl/uart_pkg.sv
hdl/uart_reg_pkg.sv
hdl/uart_rx.sv
hdl/uart_tx.sv
hdl/uart_regs.sv
hdl/uart_top.sv
verification/tb_uart_top.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the UART testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_uart_top -Mdir "$BUILD_DIR" -f project.f

"./$BUILD_DIR/Vtb_uart_top" | tee "$LOG"

if grep -q "Test failed" "$LOG"; then
    echo "Simulation reported a failure"
    exit 1
fi

echo "Simulation finished without a reported failure"
